//--- design/pe_lane_pkg.sv
`default_nettype none

package pe_lane_pkg;

    //////////////////////////////////////////////////
    // Lane word and score widths
    //////////////////////////////////////////////////

    // Bits per activation or weight word
    localparam int LANE_BITS = 7;

    // Signed score spans -7 to +7
    localparam int SCORE_BITS = 4;

    // One group of 16 lanes spans -112 to +112
    localparam int GROUP_SUM_BITS = 8;

    // Whole row spans -448 to +448
    localparam int ROW_SUM_BITS = 10;

    // Defaults handed down by the top level
    localparam int DEF_NUM_LANES   = 64;
    localparam int DEF_GROUP_LANES = 16;

    //////////////////////////////////////////////////
    // Datapath types
    //////////////////////////////////////////////////

    typedef logic [LANE_BITS-1:0] lane_word_t;

    typedef logic signed [SCORE_BITS-1:0] lane_score_t;

    typedef logic signed [GROUP_SUM_BITS-1:0] group_sum_t;

    typedef logic signed [ROW_SUM_BITS-1:0] row_sum_t;

endpackage

`default_nettype wire

//--- design/pe_ctrl_pkg.sv
`default_nettype none

package pe_ctrl_pkg;

    //////////////////////////////////////////////////
    // Row control
    //////////////////////////////////////////////////

    // Cell score, group sum, row sum
    localparam int PIPE_DEPTH = 3;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_RUN
    } ctrl_state_t;

    // Status seen by the next row and the result consumer
    typedef struct packed {
        logic out_val;
        logic next_row_en;
    } row_status_t;

endpackage

`default_nettype wire

//--- design/pe_cell.sv
`timescale 1ns/1ps
`default_nettype none

module pe_cell (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      i_new_weight_val,
    input  wire pe_lane_pkg::lane_word_t i_weight,
    input  wire pe_lane_pkg::lane_word_t i_act,
    output pe_lane_pkg::lane_word_t  o_fwd_act,
    output pe_lane_pkg::lane_score_t o_score
);

    pe_lane_pkg::lane_word_t weight_q;
    pe_lane_pkg::lane_word_t match_bits;
    logic [3:0]              match_cnt;
    logic [3:0]              score_d;

    // Agreeing bits against the weight held before this edge
    assign match_bits = ~(i_act ^ weight_q);

    always_comb begin
        match_cnt = '0;
        for (int b = 0; b < pe_lane_pkg::LANE_BITS; b++) begin
            match_cnt = match_cnt + {3'b000, match_bits[b]};
        end
        // 2*matches - 7, wraps cleanly in four bits
        score_d = (match_cnt << 1) - 4'd7;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_q  <= '0;
            o_fwd_act <= '0;
            o_score   <= '0;
        end else begin
            if (i_new_weight_val) begin
                weight_q <= i_weight;
            end
            o_fwd_act <= i_act;
            o_score   <= pe_lane_pkg::lane_score_t'(score_d);
        end
    end

endmodule

`default_nettype wire

//--- design/group_adder.sv
`timescale 1ns/1ps
`default_nettype none

module group_adder #(
    parameter int NUM_LANES   = 64,
    parameter int GROUP_LANES = 16
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire pe_lane_pkg::lane_score_t [NUM_LANES-1:0] i_scores,
    output pe_lane_pkg::row_sum_t                       o_result
);

    localparam int NUM_GROUPS = NUM_LANES / GROUP_LANES;

    pe_lane_pkg::group_sum_t [NUM_GROUPS-1:0] group_sum_d;
    pe_lane_pkg::group_sum_t [NUM_GROUPS-1:0] group_sum_q;
    pe_lane_pkg::row_sum_t                    row_sum_d;

    //////////////////////////////////////////////////
    // Stage 1, one partial sum per lane group
    //////////////////////////////////////////////////

    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            group_sum_d[g] = '0;
            for (int l = 0; l < GROUP_LANES; l++) begin
                // Sign extend each score before adding
                group_sum_d[g] = group_sum_d[g]
                    + pe_lane_pkg::group_sum_t'(i_scores[g*GROUP_LANES + l]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            group_sum_q <= '0;
        end else begin
            group_sum_q <= group_sum_d;
        end
    end

    //////////////////////////////////////////////////
    // Stage 2, row total
    //////////////////////////////////////////////////

    always_comb begin
        row_sum_d = '0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            row_sum_d = row_sum_d + pe_lane_pkg::row_sum_t'(group_sum_q[g]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_result <= '0;
        end else begin
            o_result <= row_sum_d;
        end
    end

endmodule

`default_nettype wire

//--- design/row_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module row_ctrl (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      i_new_weight_val,
    output pe_ctrl_pkg::row_status_t o_status
);

    localparam int CNT_W = $clog2(pe_ctrl_pkg::PIPE_DEPTH);

    // Last count before the pipeline holds a full set of vectors
    localparam logic [CNT_W-1:0] FILL_LAST = CNT_W'(pe_ctrl_pkg::PIPE_DEPTH - 1);

    pe_ctrl_pkg::ctrl_state_t state;
    logic [CNT_W-1:0]         fill_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= pe_ctrl_pkg::ST_IDLE;
            fill_cnt <= '0;
        end else if (i_new_weight_val) begin
            // New weights flush the whole pipeline
            state    <= pe_ctrl_pkg::ST_FILL;
            fill_cnt <= '0;
        end else begin
            case (state)
                pe_ctrl_pkg::ST_IDLE: begin
                    // Idle cycle already counts as one stage
                    state    <= pe_ctrl_pkg::ST_FILL;
                    fill_cnt <= CNT_W'(1);
                end
                pe_ctrl_pkg::ST_FILL: begin
                    if (fill_cnt == FILL_LAST) begin
                        state <= pe_ctrl_pkg::ST_RUN;
                    end else begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                end
                pe_ctrl_pkg::ST_RUN: begin
                    state <= pe_ctrl_pkg::ST_RUN;
                end
                default: begin
                    state    <= pe_ctrl_pkg::ST_IDLE;
                    fill_cnt <= '0;
                end
            endcase
        end
    end

    // Status decoded straight from the state
    always_comb begin
        o_status.out_val     = (state == pe_ctrl_pkg::ST_RUN);
        o_status.next_row_en = (state != pe_ctrl_pkg::ST_IDLE);
    end

endmodule

`default_nettype wire

//--- design/pe_row.sv
`timescale 1ns/1ps
`default_nettype none

module pe_row #(
    parameter int NUM_LANES   = pe_lane_pkg::DEF_NUM_LANES,
    parameter int GROUP_LANES = pe_lane_pkg::DEF_GROUP_LANES
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         i_new_weight_val,
    input  wire pe_lane_pkg::lane_word_t [NUM_LANES-1:0] i_weight,
    input  wire pe_lane_pkg::lane_word_t [NUM_LANES-1:0] i_act,
    output wire pe_lane_pkg::lane_word_t [NUM_LANES-1:0] o_fwd_act,
    output wire pe_lane_pkg::row_sum_t                  o_result,
    output wire pe_ctrl_pkg::row_status_t               o_status
);

    wire pe_lane_pkg::lane_score_t [NUM_LANES-1:0] lane_scores;

    //////////////////////////////////////////////////
    // Lane cells
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        pe_cell u_cell (
            .clk              (clk),
            .rst_n            (rst_n),
            .i_new_weight_val (i_new_weight_val),
            .i_weight         (i_weight[i]),
            .i_act            (i_act[i]),
            .o_fwd_act        (o_fwd_act[i]),
            .o_score          (lane_scores[i])
        );
    end

    //////////////////////////////////////////////////
    // Adder tree and control
    //////////////////////////////////////////////////

    group_adder #(
        .NUM_LANES   (NUM_LANES),
        .GROUP_LANES (GROUP_LANES)
    ) u_group_adder (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_scores (lane_scores),
        .o_result (o_result)
    );

    // Tracks pipeline fill after reset and after each weight load
    row_ctrl u_row_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_new_weight_val (i_new_weight_val),
        .o_status         (o_status)
    );

endmodule

`default_nettype wire

//--- tests/pe_row_model.svh
`ifndef PE_ROW_MODEL_SVH
`define PE_ROW_MODEL_SVH

typedef pe_lane_pkg::lane_word_t [pe_lane_pkg::DEF_NUM_LANES-1:0] lane_vec_t;

// One row of the stimulus table
typedef struct packed {
    logic                  load;
    lane_vec_t             weight;
    lane_vec_t             act;
    pe_lane_pkg::row_sum_t expected;
} stim_entry_t;

// Each agreeing bit counts +1, each differing bit -1
function automatic int lane_score(input pe_lane_pkg::lane_word_t act,
                                  input pe_lane_pkg::lane_word_t weight);
    int agree;
    agree = 0;
    for (int b = 0; b < pe_lane_pkg::LANE_BITS; b++) begin
        if (act[b] == weight[b]) begin
            agree++;
        end
    end
    return 2 * agree - pe_lane_pkg::LANE_BITS;
endfunction

function automatic pe_lane_pkg::row_sum_t row_sum(input lane_vec_t act, input lane_vec_t weight);
    int total;
    total = 0;
    for (int l = 0; l < pe_lane_pkg::DEF_NUM_LANES; l++) begin
        total += lane_score(act[l], weight[l]);
    end
    return pe_lane_pkg::row_sum_t'(total);
endfunction

`endif

//--- tests/pe_row_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pe_row_tb;

    `include "pe_row_model.svh"

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_LANES      = pe_lane_pkg::DEF_NUM_LANES;
    localparam int NUM_BLOCKS     = 6;
    localparam int NUM_ENTRIES    = NUM_BLOCKS * 5;
    // One edge to sample with the cell score, then group sum and row sum
    localparam int RESULT_LAG     = 3;
    localparam int FILL_EDGES     = 3;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ENTRIES + pe_ctrl_pkg::PIPE_DEPTH + 20;

    logic                     clk;
    logic                     rst_n;
    logic                     i_new_weight_val;
    lane_vec_t                i_weight;
    lane_vec_t                i_act;
    lane_vec_t                o_fwd_act;
    pe_lane_pkg::row_sum_t    o_result;
    pe_ctrl_pkg::row_status_t o_status;

    stim_entry_t                 stim_table [NUM_ENTRIES];
    pe_lane_pkg::row_sum_t       pending [$];
    pe_ctrl_pkg::row_status_t    exp_status;
    integer                      seed = 32'h8828_a2f9;
    int                          cycle_cnt = 0;
    int                          result_errors = 0;
    int                          lane_errors = 0;
    int                          status_errors = 0;

    pe_row DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_new_weight_val (i_new_weight_val),
        .i_weight         (i_weight),
        .i_act            (i_act),
        .o_fwd_act        (o_fwd_act),
        .o_result         (o_result),
        .o_status         (o_status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing the table", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_result(input pe_lane_pkg::row_sum_t got,
                                input pe_lane_pkg::row_sum_t expected, input string what);
        if (got !== expected) begin
            result_errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic check_lanes(input lane_vec_t got, input lane_vec_t expected);
        int first_bad;
        first_bad = -1;
        for (int l = NUM_LANES - 1; l >= 0; l--) begin
            if (got[l] !== expected[l]) begin
                first_bad = l;
            end
        end
        if (first_bad >= 0) begin
            lane_errors++;
            $display("mismatch at %0t: o_fwd_act lane %0d is %h, expected %h",
                     $time, first_bad, got[first_bad], expected[first_bad]);
        end
    endtask

    task automatic check_status(input pe_ctrl_pkg::row_status_t got,
                                input pe_ctrl_pkg::row_status_t expected, input string what);
        if (got !== expected) begin
            status_errors++;
            $display("mismatch at %0t: %s status out_val %b next_row_en %b, expected %b %b",
                     $time, what, got.out_val, got.next_row_en,
                     expected.out_val, expected.next_row_en);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    function automatic lane_vec_t random_vec();
        lane_vec_t v;
        int        rnd;
        for (int l = 0; l < NUM_LANES; l++) begin
            rnd  = $random(seed);
            v[l] = rnd[pe_lane_pkg::LANE_BITS-1:0];
        end
        return v;
    endfunction

    task automatic build_table();
        lane_vec_t cur_w;
        lane_vec_t new_w;
        int        idx;
        cur_w = '0;
        idx   = 0;
        for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
            new_w = random_vec();
            stim_table[idx].load   = 1'b1;
            stim_table[idx].weight = new_w;
            stim_table[idx].act    = random_vec();
            // Activation on the load edge still meets the old weights
            stim_table[idx].expected = row_sum(stim_table[idx].act, cur_w);
            cur_w = new_w;
            idx++;
            for (int k = 0; k < 4; k++) begin
                stim_table[idx].load   = 1'b0;
                stim_table[idx].weight = cur_w;
                if ((blk == 0 || blk == 3) && k == 0) begin
                    stim_table[idx].act      = cur_w;
                    stim_table[idx].expected = pe_lane_pkg::row_sum_t'(448);
                end else if ((blk == 0 || blk == 3) && k == 1) begin
                    stim_table[idx].act      = ~cur_w;
                    stim_table[idx].expected = pe_lane_pkg::row_sum_t'(-448);
                end else begin
                    stim_table[idx].act      = random_vec();
                    stim_table[idx].expected = row_sum(stim_table[idx].act, cur_w);
                end
                idx++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        lane_vec_t drv_act;
        lane_vec_t sampled_act;
        logic      drv_load;
        logic      sampled_load;
        int        fill_edges;
        int        total_errors;

        rst_n            = 1'b0;
        i_new_weight_val = 1'b0;
        i_weight         = '0;
        i_act            = '0;
        drv_act          = '0;
        drv_load         = 1'b0;
        fill_edges       = 0;
        build_table();

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_status(o_status, '0, "reset");
            check_result(o_result, '0, "o_result in reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_status(o_status, '0, "release");
        check_result(o_result, '0, "o_result after release");

        // Pipeline fill after reset with no weight load
        for (int j = 0; j <= FILL_EDGES; j++) begin
            @(posedge clk);
            fill_edges++;
            @(negedge clk);
            exp_status.out_val     = (fill_edges >= FILL_EDGES);
            exp_status.next_row_en = 1'b1;
            check_status(o_status, exp_status, "fill");
            check_lanes(o_fwd_act, '0);
        end

        for (int j = 0; j < NUM_ENTRIES + RESULT_LAG; j++) begin
            @(posedge clk);
            sampled_load = drv_load;
            sampled_act  = drv_act;
            if (j < NUM_ENTRIES) begin
                i_new_weight_val <= stim_table[j].load;
                i_weight         <= stim_table[j].weight;
                i_act            <= stim_table[j].act;
                drv_load = stim_table[j].load;
                drv_act  = stim_table[j].act;
                pending.push_back(stim_table[j].expected);
            end else begin
                i_new_weight_val <= 1'b0;
                drv_load = 1'b0;
            end
            fill_edges = sampled_load ? 0 : fill_edges + 1;

            @(negedge clk);
            exp_status.out_val     = (fill_edges >= FILL_EDGES);
            exp_status.next_row_en = 1'b1;
            check_status(o_status, exp_status, "run");
            check_lanes(o_fwd_act, sampled_act);
            if (j >= RESULT_LAG) begin
                check_result(o_result, pending.pop_front(), "o_result");
            end
        end

        total_errors = result_errors + lane_errors + status_errors;
        $display("Errors: result %0d, lanes %0d, status %0d",
                 result_errors, lane_errors, status_errors);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+tests
design/pe_lane_pkg.sv
design/pe_ctrl_pkg.sv
design/pe_cell.sv
design/group_adder.sv
design/row_ctrl.sv
design/pe_row.sv
tests/pe_row_tb.sv

//--- Makefile
# Verilator flow for the binarized PE row

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= pe_row_tb
RTL_TOP   ?= pe_row
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= Simulation passed

SRCS := $(shell grep -v '^+' $(FILELIST)) tests/pe_row_model.svh
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing -Wno-fatal $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
